// File: hdl/dcache_ctrl.sv
// lookup stage, hit and victim logic, write forwarding, byte merge, cache FSM
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  req_valid_i,
    output logic                                  req_ready_o,
    input  logic [`DC_ADDR_W-1:0]                 req_addr_i,
    input  logic                                  req_write_i,
    input  dcache_pkg::word_t                     req_wdata_i,
    input  logic [`DC_BE_W-1:0]                   req_be_i,
    output logic                                  resp_valid_o,
    output dcache_pkg::word_t                     resp_rdata_o,
    output logic [`DC_INDEX_W-1:0]                ram_raddr_o,
    output logic [`DC_INDEX_W-1:0]                ram_waddr_o,
    output dcache_pkg::way_mask_t                 tag_we_o,
    output dcache_pkg::tag_entry_t                tag_wdata_o,
    input  dcache_pkg::tag_entry_t [`DC_WAYS-1:0] tag_rdata_i,
    output dcache_pkg::way_mask_t                 data_we_o,
    output dcache_pkg::line_t                     data_wdata_o,
    input  dcache_pkg::line_t [`DC_WAYS-1:0]      data_rdata_i,
    output logic                                  plru_access_o,
    output logic [`DC_INDEX_W-1:0]                plru_set_o,
    output logic [`DC_WAY_W-1:0]                  plru_way_o,
    input  logic [`DC_WAY_W-1:0]                  plru_victim_i,
    output logic                                  xfer_start_o,
    output logic                                  xfer_write_o,
    output logic [`DC_ADDR_W-1:0]                 xfer_addr_o,
    output dcache_pkg::line_t                     xfer_wline_o,
    input  logic                                  xfer_done_i,
    input  dcache_pkg::line_t                     xfer_rline_i
);
    import dcache_pkg::*;

    localparam int LOW_W = `DC_WORD_OFF_W + `DC_LINE_OFF_W;

    ctrl_state_t               state;
    logic [`DC_INDEX_W-1:0]    rst_cnt;
    logic                      lk_valid;
    logic [`DC_ADDR_W-1:0]     lk_addr;
    logic                      lk_write;
    word_t                     lk_wdata;
    logic [`DC_BE_W-1:0]       lk_be;
    logic [`DC_TAG_W-1:0]      lk_tag;
    logic [`DC_INDEX_W-1:0]    lk_index;
    logic [`DC_LINE_OFF_W-1:0] lk_word;
    way_mask_t                 fwd_we;
    logic [`DC_INDEX_W-1:0]    fwd_index;
    tag_entry_t                fwd_tag;
    line_t                     fwd_line;
    tag_entry_t [`DC_WAYS-1:0] tag_eff;
    line_t [`DC_WAYS-1:0]      line_eff;
    way_mask_t                 hit;
    logic [`DC_WAY_W-1:0]      hit_way;
    line_t                     hit_line;
    logic                      miss;
    logic [`DC_WAY_W-1:0]      vic_way;
    logic [`DC_WAY_W-1:0]      vic_way_q;
    logic                      vic_dirty;
    logic                      fill_done;

    function automatic line_t merge_store(line_t line, logic [`DC_LINE_OFF_W-1:0] word,
                                          word_t wdata, logic [`DC_BE_W-1:0] be);
        line_t merged;
        merged = line;
        for (int b = 0; b < `DC_BE_W; b++) begin
            if (be[b]) begin
                merged[word][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign lk_tag      = lk_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign lk_index    = lk_addr[LOW_W +: `DC_INDEX_W];
    assign lk_word     = lk_addr[`DC_WORD_OFF_W +: `DC_LINE_OFF_W];
    assign ram_raddr_o = req_addr_i[LOW_W +: `DC_INDEX_W];

    // lookup register, held while a miss is being served
    always_ff @(posedge clk) begin
        if (rst) begin
            lk_valid <= 1'b0;
        end else if (req_ready_o) begin
            lk_valid <= req_valid_i;
        end else if (fill_done) begin
            lk_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready_o && req_valid_i) begin
            lk_addr  <= req_addr_i;
            lk_write <= req_write_i;
            lk_wdata <= req_wdata_i;
            lk_be    <= req_be_i;
        end
    end

    // a write in the last cycle is not yet visible at the RAM output
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (fwd_we[w] && fwd_index == lk_index) begin
                tag_eff[w]  = fwd_tag;
                line_eff[w] = fwd_line;
            end else begin
                tag_eff[w]  = tag_rdata_i[w];
                line_eff[w] = data_rdata_i[w];
            end
        end
    end

    always_comb begin
        hit      = '0;
        hit_way  = '0;
        hit_line = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (tag_eff[w].valid && tag_eff[w].tag == lk_tag) begin
                hit[w]   = 1'b1;
                hit_way  = w[`DC_WAY_W-1:0];
                hit_line = line_eff[w];
            end
        end
    end

    // lowest invalid way first, else the PLRU choice
    always_comb begin
        vic_way = plru_victim_i;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!tag_eff[w].valid) begin
                vic_way = w[`DC_WAY_W-1:0];
            end
        end
    end

    assign vic_dirty   = tag_eff[vic_way].valid && tag_eff[vic_way].dirty;
    assign miss        = (state == IDLE) && lk_valid && !(|hit);
    assign fill_done   = (state == REFILL) && xfer_done_i;
    assign req_ready_o = (state == IDLE) && !miss;

    assign resp_valid_o = lk_valid && !lk_write && (((state == IDLE) && |hit) || fill_done);
    assign resp_rdata_o = fill_done ? xfer_rline_i[lk_word] : hit_line[lk_word];

    assign plru_access_o = ((state == IDLE) && lk_valid && |hit) || fill_done;
    assign plru_set_o    = lk_index;
    assign plru_way_o    = fill_done ? vic_way_q : hit_way;

    // write-back starts from the lookup cycle, refill after it or directly
    assign xfer_start_o = miss || ((state == WRITEBACK) && xfer_done_i);
    assign xfer_write_o = (state == IDLE) && vic_dirty;
    assign xfer_addr_o  = xfer_write_o ? {tag_eff[vic_way].tag, lk_index, {LOW_W{1'b0}}}
                                       : {lk_tag, lk_index, {LOW_W{1'b0}}};
    assign xfer_wline_o = line_eff[vic_way];

    always_comb begin
        tag_we_o     = '0;
        data_we_o    = '0;
        ram_waddr_o  = lk_index;
        tag_wdata_o  = '{valid: 1'b1, dirty: lk_write, tag: lk_tag};
        data_wdata_o = merge_store(hit_line, lk_word, lk_wdata, lk_be);
        case (state)
            RESET: begin
                tag_we_o    = '1;
                ram_waddr_o = rst_cnt;
                tag_wdata_o = '0;
            end
            IDLE: begin
                if (lk_valid && lk_write && |hit) begin
                    tag_we_o  = hit;
                    data_we_o = hit;
                end
            end
            REFILL: begin
                // store miss merges into the fresh line
                data_wdata_o = lk_write ? merge_store(xfer_rline_i, lk_word, lk_wdata, lk_be)
                                        : xfer_rline_i;
                if (xfer_done_i) begin
                    tag_we_o[vic_way_q]  = 1'b1;
                    data_we_o[vic_way_q] = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_we <= '0;
        end else begin
            fwd_we <= data_we_o;
        end
    end

    always_ff @(posedge clk) begin
        fwd_index <= ram_waddr_o;
        fwd_tag   <= tag_wdata_o;
        fwd_line  <= data_wdata_o;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RESET;
            rst_cnt   <= '0;
            vic_way_q <= '0;
        end else begin
            case (state)
                RESET: begin
                    // one set per cycle
                    rst_cnt <= rst_cnt + 1'b1;
                    if (&rst_cnt) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (miss) begin
                        vic_way_q <= vic_way;
                        state     <= vic_dirty ? WRITEBACK : REFILL;
                    end
                end
                WRITEBACK: begin
                    if (xfer_done_i) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (fill_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: hdl/dcache_defs.svh
// cache geometry, word and address field width macros
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// byte address and data word
`define DC_ADDR_W      32
`define DC_DATA_W      32
`define DC_BE_W        4

// line and set organization
`define DC_WORDS       4
`define DC_WAYS        4
`define DC_SETS        16

// address split, low to high: byte, word, index, tag
`define DC_WORD_OFF_W  2
`define DC_LINE_OFF_W  2
`define DC_INDEX_W     4
`define DC_TAG_W       (`DC_ADDR_W - `DC_INDEX_W - `DC_LINE_OFF_W - `DC_WORD_OFF_W)

// way number
`define DC_WAY_W       2

`endif

// File: hdl/dcache_line_xfer.sv
// memory port burst engine for line write-back and line refill
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_line_xfer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  xfer_start_i,
    input  logic                  xfer_write_i,
    input  logic [`DC_ADDR_W-1:0] xfer_addr_i,
    input  dcache_pkg::line_t     xfer_wline_i,
    output logic                  xfer_done_o,
    output dcache_pkg::line_t     xfer_rline_o,
    output logic                  mem_req_valid_o,
    output logic [`DC_ADDR_W-1:0] mem_req_addr_o,
    output logic                  mem_req_write_o,
    input  logic                  mem_req_ready_i,
    output dcache_pkg::word_t     mem_wdata_o,
    output logic                  mem_wvalid_o,
    input  logic                  mem_wready_i,
    input  dcache_pkg::word_t     mem_rdata_i,
    input  logic                  mem_rvalid_i
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        XF_IDLE,
        XF_REQ,
        XF_WBEAT,
        XF_RBEAT
    } xf_state_t;

    xf_state_t                 state;
    logic [`DC_LINE_OFF_W-1:0] beat_cnt;
    logic                      last_beat;
    logic                      done_q;
    logic                      write_q;
    logic [`DC_ADDR_W-1:0]     addr_q;
    line_t                     wline_q;
    line_t                     rline_q;

    // counter wraps back to zero after the last word
    assign last_beat = &beat_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= XF_IDLE;
            beat_cnt <= '0;
            done_q   <= 1'b0;
            write_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                XF_IDLE: begin
                    if (xfer_start_i) begin
                        state   <= XF_REQ;
                        write_q <= xfer_write_i;
                    end
                end
                XF_REQ: begin
                    if (mem_req_ready_i) begin
                        state <= write_q ? XF_WBEAT : XF_RBEAT;
                    end
                end
                XF_WBEAT: begin
                    if (mem_wready_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state  <= XF_IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end
                XF_RBEAT: begin
                    if (mem_rvalid_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state  <= XF_IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end
                default: state <= XF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == XF_IDLE && xfer_start_i) begin
            addr_q  <= xfer_addr_i;
            wline_q <= xfer_wline_i;
        end
        // lowest word arrives first, so shift down from the top
        if (state == XF_RBEAT && mem_rvalid_i) begin
            rline_q <= {mem_rdata_i, rline_q[`DC_WORDS-1:1]};
        end
    end

    assign mem_req_valid_o = (state == XF_REQ);
    assign mem_req_addr_o  = addr_q;
    assign mem_req_write_o = write_q;
    assign mem_wvalid_o    = (state == XF_WBEAT);
    assign mem_wdata_o     = wline_q[beat_cnt];
    assign xfer_done_o     = done_q;
    assign xfer_rline_o    = rline_q;

endmodule

// File: hdl/dcache_pkg.sv
// shared cache types: data word, line, tag entry, way mask, control states
`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic [`DC_DATA_W-1:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [`DC_WORDS-1:0] line_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`DC_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef logic [`DC_WAYS-1:0] way_mask_t;

    typedef enum logic [1:0] {
        RESET,
        IDLE,
        WRITEBACK,
        REFILL
    } ctrl_state_t;

endpackage

// File: hdl/dcache_plru.sv
// tree pseudo-LRU state per set with access update and victim select
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_plru (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   access_i,
    input  logic [`DC_INDEX_W-1:0] access_set_i,
    input  logic [`DC_WAY_W-1:0]   access_way_i,
    input  logic [`DC_INDEX_W-1:0] victim_set_i,
    output logic [`DC_WAY_W-1:0]   victim_way_o
);

    // bit 0 root, bit 1 picks in ways 0/1, bit 2 picks in ways 2/3
    logic [`DC_SETS-1:0][2:0] tree;
    logic [2:0]               vic_bits;

    always_ff @(posedge clk) begin
        if (rst) begin
            tree <= '0;
        end else if (access_i) begin
            // root turns to the other half
            tree[access_set_i][0] <= ~access_way_i[1];
            if (access_way_i[1]) begin
                tree[access_set_i][2] <= ~access_way_i[0];
            end else begin
                tree[access_set_i][1] <= ~access_way_i[0];
            end
        end
    end

    assign vic_bits = tree[victim_set_i];

    // follow root, then the pair bit of that half
    assign victim_way_o = vic_bits[0] ? {1'b1, vic_bits[2]} : {1'b0, vic_bits[1]};

endmodule

// File: hdl/dcache_ram.sv
// per-set storage RAM with registered read and a single write port
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ram #(
    parameter type dtype = logic,
    parameter int  DEPTH = `DC_SETS
) (
    input  logic                   clk,
    input  logic                   we_i,
    input  logic [`DC_INDEX_W-1:0] waddr_i,
    input  logic [`DC_INDEX_W-1:0] raddr_i,
    input  dtype                   wdata_i,
    output dtype                   rdata_o
);

    dtype mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read before write on a same-set collision
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

// File: hdl/dcache_top.sv
// data cache top: control, per-way tag and line RAMs, PLRU, memory burst engine
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  logic [`DC_ADDR_W-1:0] req_addr_i,
    input  logic                  req_write_i,
    input  dcache_pkg::word_t     req_wdata_i,
    input  logic [`DC_BE_W-1:0]   req_be_i,
    output logic                  resp_valid_o,
    output dcache_pkg::word_t     resp_rdata_o,
    output logic                  mem_req_valid_o,
    output logic [`DC_ADDR_W-1:0] mem_req_addr_o,
    output logic                  mem_req_write_o,
    input  logic                  mem_req_ready_i,
    output dcache_pkg::word_t     mem_wdata_o,
    output logic                  mem_wvalid_o,
    input  logic                  mem_wready_i,
    input  dcache_pkg::word_t     mem_rdata_i,
    input  logic                  mem_rvalid_i
);
    import dcache_pkg::*;

    logic [`DC_INDEX_W-1:0]    ram_raddr;
    logic [`DC_INDEX_W-1:0]    ram_waddr;
    way_mask_t                 tag_we;
    tag_entry_t                tag_wdata;
    tag_entry_t [`DC_WAYS-1:0] tag_rdata;
    way_mask_t                 data_we;
    line_t                     data_wdata;
    line_t [`DC_WAYS-1:0]      data_rdata;
    logic                      plru_access;
    logic [`DC_INDEX_W-1:0]    plru_set;
    logic [`DC_WAY_W-1:0]      plru_way;
    logic [`DC_WAY_W-1:0]      plru_victim;
    logic                      xfer_start;
    logic                      xfer_write;
    logic [`DC_ADDR_W-1:0]     xfer_addr;
    line_t                     xfer_wline;
    logic                      xfer_done;
    line_t                     xfer_rline;

    // CPU side ports connect by name
    dcache_ctrl u_ctrl (
        .ram_raddr_o   (ram_raddr),
        .ram_waddr_o   (ram_waddr),
        .tag_we_o      (tag_we),
        .tag_wdata_o   (tag_wdata),
        .tag_rdata_i   (tag_rdata),
        .data_we_o     (data_we),
        .data_wdata_o  (data_wdata),
        .data_rdata_i  (data_rdata),
        .plru_access_o (plru_access),
        .plru_set_o    (plru_set),
        .plru_way_o    (plru_way),
        .plru_victim_i (plru_victim),
        .xfer_start_o  (xfer_start),
        .xfer_write_o  (xfer_write),
        .xfer_addr_o   (xfer_addr),
        .xfer_wline_o  (xfer_wline),
        .xfer_done_i   (xfer_done),
        .xfer_rline_i  (xfer_rline),
        .*
    );

    // victim and access share the lookup set
    dcache_plru u_plru (
        .clk          (clk),
        .rst          (rst),
        .access_i     (plru_access),
        .access_set_i (plru_set),
        .access_way_i (plru_way),
        .victim_set_i (plru_set),
        .victim_way_o (plru_victim)
    );

    // memory port signals connect by name
    dcache_line_xfer u_xfer (
        .xfer_start_i (xfer_start),
        .xfer_write_i (xfer_write),
        .xfer_addr_i  (xfer_addr),
        .xfer_wline_i (xfer_wline),
        .xfer_done_o  (xfer_done),
        .xfer_rline_o (xfer_rline),
        .*
    );

    for (genvar w = 0; w < `DC_WAYS; w++) begin : gen_way
        dcache_ram #(
            .dtype (tag_entry_t),
            .DEPTH (`DC_SETS)
        ) u_tag_ram (
            .clk     (clk),
            .we_i    (tag_we[w]),
            .waddr_i (ram_waddr),
            .raddr_i (ram_raddr),
            .wdata_i (tag_wdata),
            .rdata_o (tag_rdata[w])
        );

        dcache_ram #(
            .dtype (line_t),
            .DEPTH (`DC_SETS)
        ) u_data_ram (
            .clk     (clk),
            .we_i    (data_we[w]),
            .waddr_i (ram_waddr),
            .raddr_i (ram_raddr),
            .wdata_i (data_wdata),
            .rdata_o (data_rdata[w])
        );
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_dcache -Mdir obj_dir -o tb_dcache

./obj_dir/tb_dcache > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST PASSED" sim.log

// File: sim.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_ram.sv
hdl/dcache_plru.sv
hdl/dcache_line_xfer.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tb/tb_mem_model.sv
tb/tb_dcache.sv

// File: tb/tb_dcache.sv
// data cache testbench with clock, reset, stimulus table, reference model, checks and timeout
`timescale 1ns/1ps
`include "dcache_defs.svh"

module tb_dcache;

    logic        clk;
    logic        rst;
    logic        req_valid_i;
    logic        req_ready_o;
    logic [31:0] req_addr_i;
    logic        req_write_i;
    logic [31:0] req_wdata_i;
    logic [3:0]  req_be_i;
    logic        resp_valid_o;
    logic [31:0] resp_rdata_o;
    logic        mem_req_valid_o;
    logic [31:0] mem_req_addr_o;
    logic        mem_req_write_o;
    logic        mem_req_ready_i;
    logic [31:0] mem_wdata_o;
    logic        mem_wvalid_o;
    logic        mem_wready_i;
    logic [31:0] mem_rdata_i;
    logic        mem_rvalid_i;

    // stimulus table
    logic        wr_tab   [64];
    logic [31:0] addr_tab [64];
    logic [31:0] data_tab [64];
    logic [3:0]  be_tab   [64];
    logic [31:0] exp_tab  [64];
    int          n_ops;

    // reference CPU view of memory, tags and PLRU tree bits
    logic [7:0]  view  [2048];
    logic [23:0] rtag  [16][4];
    logic        rval  [16][4];
    logic        rdirty[16][4];
    logic [2:0]  rtree [16];

    logic [32:0] req_q[$];
    logic [31:0] wbeat_q[$];
    int          load_q[$];
    int          cycles;
    int          cycle_limit;

    dcache_top UUT (.*);

    tb_mem_model u_mem (
        .clk             (clk),
        .rst             (rst),
        .mem_req_valid_i (mem_req_valid_o),
        .mem_req_addr_i  (mem_req_addr_o),
        .mem_req_write_i (mem_req_write_o),
        .mem_req_ready_o (mem_req_ready_i),
        .mem_wdata_i     (mem_wdata_o),
        .mem_wvalid_i    (mem_wvalid_o),
        .mem_wready_o    (mem_wready_i),
        .mem_rdata_o     (mem_rdata_i),
        .mem_rvalid_o    (mem_rvalid_i)
    );

    function automatic logic [31:0] fill_word(logic [31:0] a);
        return (a * 32'h9e3779b1) ^ 32'h0badc0de;
    endfunction

    function automatic logic [31:0] view_word(logic [31:0] a);
        logic [10:0] b;
        b = {a[10:2], 2'b00};
        return {view[b + 3], view[b + 2], view[b + 1], view[b]};
    endfunction

    // root set means the upper pair is older
    function automatic int plru_pick(int idx);
        if (rtree[idx][0]) return rtree[idx][2] ? 3 : 2;
        return rtree[idx][1] ? 1 : 0;
    endfunction

    task automatic plru_touch(input int idx, input int w);
        rtree[idx][0] = (w < 2);
        if (w < 2) rtree[idx][1] = (w == 0);
        else rtree[idx][2] = (w == 2);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, got %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // appends one entry and advances the reference model
    task automatic add_op(input logic wr, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] be);
        int          idx;
        int          w;
        logic [31:0] wa;
        idx = a[7:4];
        w   = -1;
        for (int k = 0; k < 4; k++) begin
            if (rval[idx][k] && rtag[idx][k] == a[31:8]) w = k;
        end
        if (w < 0) begin
            for (int k = 3; k >= 0; k--) begin
                if (!rval[idx][k]) w = k;
            end
            if (w < 0) w = plru_pick(idx);
            if (rval[idx][w] && rdirty[idx][w]) begin
                wa = {rtag[idx][w], a[7:4], 4'b0000};
                req_q.push_back({1'b1, wa});
                for (int b = 0; b < 4; b++) wbeat_q.push_back(view_word(wa + 4 * b));
            end
            req_q.push_back({1'b0, a[31:4], 4'b0000});
            rval[idx][w]   = 1'b1;
            rtag[idx][w]   = a[31:8];
            rdirty[idx][w] = 1'b0;
        end
        plru_touch(idx, w);
        if (wr) begin
            rdirty[idx][w] = 1'b1;
            for (int b = 0; b < 4; b++) begin
                if (be[b]) view[{a[10:2], 2'b00} + b] = d[8*b +: 8];
            end
        end else begin
            load_q.push_back(n_ops);
        end
        wr_tab[n_ops]   = wr;
        addr_tab[n_ops] = a;
        data_tab[n_ops] = d;
        be_tab[n_ops]   = be;
        exp_tab[n_ops]  = view_word(a);
        n_ops           = n_ops + 1;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // roughly 40 cycles per entry covers write-back, refill and stalls
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("TEST FAILED");
            $fatal(1, "timeout: the cache stopped answering after %0d cycles", cycles);
        end
    end

    // responses, memory requests and write beats are checked in order
    always @(negedge clk) begin
        if (!rst && resp_valid_o) begin
            if (load_q.size() == 0) begin
                $display("TEST FAILED");
                $fatal(1, "the cache gave a load response that no request asked for");
            end
            check_value($sformatf("load %0d at %h", load_q[0], addr_tab[load_q[0]]),
                        exp_tab[load_q[0]], resp_rdata_o);
            void'(load_q.pop_front());
        end
        if (!rst && mem_req_valid_o && mem_req_ready_i) begin
            if (req_q.size() == 0) begin
                $display("TEST FAILED");
                $fatal(1, "the cache sent a memory request that was not expected");
            end
            check_value("memory request write", req_q[0][32], mem_req_write_o);
            check_value("memory request address", req_q[0][31:0], mem_req_addr_o);
            void'(req_q.pop_front());
        end
        if (!rst && mem_wvalid_o && mem_wready_i) begin
            if (wbeat_q.size() == 0) begin
                $display("TEST FAILED");
                $fatal(1, "the cache sent a write beat that was not expected");
            end
            check_value("write-back beat", wbeat_q[0], mem_wdata_o);
            void'(wbeat_q.pop_front());
        end
    end

    initial begin
        rst         = 1'b1;
        req_valid_i = 1'b0;
        req_addr_i  = '0;
        req_write_i = 1'b0;
        req_wdata_i = '0;
        req_be_i    = '0;
        cycles      = 0;
        cycle_limit = 100000;
        n_ops       = 0;
        for (int i = 0; i < 2048; i += 4) begin
            u_mem.mem[i / 4] = fill_word(i);
            {view[i + 3], view[i + 2], view[i + 1], view[i]} = fill_word(i);
        end
        for (int s = 0; s < 16; s++) begin
            rtree[s] = '0;
            for (int w = 0; w < 4; w++) begin
                rval[s][w]   = 1'b0;
                rdirty[s][w] = 1'b0;
                rtag[s][w]   = '0;
            end
        end
        // first loads, then a partial store and a back-to-back store and load
        add_op(0, 32'h000, 0, 0);
        add_op(0, 32'h010, 0, 0);
        add_op(0, 32'h020, 0, 0);
        add_op(0, 32'h030, 0, 0);
        add_op(0, 32'h004, 0, 0);
        add_op(1, 32'h014, 32'hdeadbeef, 4'b0101);
        add_op(0, 32'h014, 0, 0);
        add_op(0, 32'h010, 0, 0);
        add_op(1, 32'h028, 32'h12345678, 4'b1111);
        add_op(0, 32'h028, 0, 0);
        add_op(1, 32'h044, 32'h0000a55a, 4'b0011);
        add_op(0, 32'h044, 0, 0);
        // fill set 5, dirty ways 2 and 3, touch way 0, then evict
        add_op(0, 32'h050, 0, 0);
        add_op(0, 32'h150, 0, 0);
        add_op(0, 32'h250, 0, 0);
        add_op(0, 32'h350, 0, 0);
        add_op(1, 32'h258, 32'hcafef00d, 4'b1111);
        add_op(1, 32'h35c, 32'h89abcdef, 4'b1100);
        add_op(0, 32'h054, 0, 0);
        add_op(0, 32'h450, 0, 0);
        add_op(0, 32'h258, 0, 0);
        add_op(0, 32'h35c, 0, 0);
        add_op(1, 32'h560, 32'h600dd00d, 4'b1000);
        add_op(0, 32'h550, 0, 0);
        add_op(0, 32'h650, 0, 0);
        add_op(0, 32'h35c, 0, 0);
        add_op(0, 32'h560, 0, 0);
        cycle_limit = n_ops * 40 + `DC_SETS + 10 + 20;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        // port stays closed while the reset walk clears one set per cycle
        repeat (`DC_SETS) begin
            @(negedge clk);
            check_value("ready during reset walk", 0, req_ready_o);
        end
        @(negedge clk);
        check_value("ready after reset walk", 1, req_ready_o);
        @(posedge clk);
        #1;
        for (int i = 0; i < n_ops; i++) begin
            req_valid_i = 1'b1;
            req_addr_i  = addr_tab[i];
            req_write_i = wr_tab[i];
            req_wdata_i = data_tab[i];
            req_be_i    = be_tab[i];
            do @(negedge clk); while (!req_ready_o);
            @(posedge clk);
            #1;
        end
        req_valid_i = 1'b0;
        while (load_q.size() != 0 || req_q.size() != 0 || wbeat_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: tb/tb_mem_model.sv
// behavioral line memory for the cache memory port with random ready stalls
`timescale 1ns/1ps
`include "dcache_defs.svh"

module tb_mem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_req_valid_i,
    input  logic [`DC_ADDR_W-1:0] mem_req_addr_i,
    input  logic                  mem_req_write_i,
    output logic                  mem_req_ready_o,
    input  logic [`DC_DATA_W-1:0] mem_wdata_i,
    input  logic                  mem_wvalid_i,
    output logic                  mem_wready_o,
    output logic [`DC_DATA_W-1:0] mem_rdata_o,
    output logic                  mem_rvalid_o
);

    // 2 KB of word storage, filled by the testbench at time zero
    logic [`DC_DATA_W-1:0] mem [512];
    integer                seed;
    int                    mode;
    int                    beat;
    logic [8:0]            base;

    initial begin
        seed            = 32'h2f169cdb;
        mode            = 0;
        beat            = 0;
        base            = '0;
        mem_req_ready_o = 1'b0;
        mem_wready_o    = 1'b0;
        mem_rdata_o     = '0;
        mem_rvalid_o    = 1'b0;
    end

    // mode 0 waits for a request, 1 takes write beats, 2 returns read beats
    always @(posedge clk) begin
        if (rst) begin
            mode = 0;
            beat = 0;
        end else if (mode == 0 && mem_req_valid_i && mem_req_ready_o) begin
            base = mem_req_addr_i[10:2];
            beat = 0;
            mode = mem_req_write_i ? 1 : 2;
        end else if (mode == 1 && mem_wvalid_i && mem_wready_o) begin
            mem[base + beat] = mem_wdata_i;
            beat = beat + 1;
            if (beat == `DC_WORDS) mode = 0;
        end else if (mode == 2 && mem_rvalid_o) begin
            beat = beat + 1;
            if (beat == `DC_WORDS) mode = 0;
        end
        #1;
        mem_req_ready_o = !rst && (mode == 0) && (($random(seed) & 3) != 0);
        mem_wready_o    = !rst && (mode == 1) && (($random(seed) & 3) != 0);
        mem_rvalid_o    = !rst && (mode == 2) && (($random(seed) & 3) != 0);
        mem_rdata_o     = mem[base + beat];
    end

endmodule
